//--- vlog.f
+incdir+include
design/mul_types_pkg.sv
design/mul_core_if.sv
design/shift_add_multiplier.sv
design/fu_wrapper_mult.sv
design/phys_regfile.sv
design/mul_unit_top.sv
sim/tb_mul_unit.sv

//--- Bender.yml
package:
  name: mul_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/mul_types_pkg.sv
      - design/mul_core_if.sv
      - design/shift_add_multiplier.sv
      - design/fu_wrapper_mult.sv
      - design/phys_regfile.sv
      - design/mul_unit_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_mul_unit.sv

//--- sim/tb_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module tb_mul_unit;
    import mul_types_pkg::*;

    localparam int N_ZERO   = 8;
    localparam int N_RAND   = 60;
    localparam int N_CORNER = 100;
    localparam int N_READY  = 4;
    localparam int N_CHAIN  = 16;
    localparam int N_BURST  = 20;
    localparam int N_ISSUES = N_ZERO + N_RAND + N_CORNER + N_READY + N_CHAIN + N_BURST;
    // 40 cycles per multiply, plus room for bus loading and reset
    localparam longint WATCHDOG_NS = (longint'(N_ISSUES) * 40 + 2000) * 40;

    logic                   clk;
    logic                   rst;
    logic                   issue_start;
    logic [`MUL_TAG_W-1:0]  issue_rob_tag;
    logic [`MUL_PREG_W-1:0] issue_pd;
    logic [`MUL_PREG_W-1:0] issue_ps1;
    logic [`MUL_PREG_W-1:0] issue_ps2;
    mul_op_t                issue_mul_type;
    logic                   fu_ready;
    logic                   bus_we;
    logic [`MUL_PREG_W-1:0] bus_pd;
    logic [`MUL_XLEN-1:0]   bus_data;
    logic                   wb_valid;
    logic [`MUL_TAG_W-1:0]  wb_rob_tag;
    logic [`MUL_PREG_W-1:0] wb_pd;
    logic [`MUL_XLEN-1:0]   wb_value;

    // Shadow copy of the register file
    logic [`MUL_XLEN-1:0]   shadow [`MUL_PREGS];
    logic [31:0]            lfsr_state;
    logic [`MUL_TAG_W-1:0]  next_tag;
    logic                   in_flight;
    int                     errors;
    int                     passed;
    int                     failed;
    int                     issued;
    int                     wb_seen;

    mul_unit_top uut (.*);

    always #20 clk = ~clk;

    // Galois form, x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb)
            s = s ^ 32'hD000_0001;
        return s;
    endfunction

    // One LFSR step for every bit handed out
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Reference product from 64-bit arithmetic, sign extension per variant
    function automatic logic [`MUL_XLEN-1:0] expected_product(input mul_op_t op,
            input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic        [63:0] ua;
        logic        [63:0] ub;
        logic        [63:0] prod;
        ua = {32'b0, a};
        ub = {32'b0, b};
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (op)
            op_mulh:   prod = sa * sb;
            op_mulhsu: prod = sa * $signed(ub);
            default:   prod = ua * ub;
        endcase
        return (op == op_mul) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic check_word(input string name, input logic [`MUL_XLEN-1:0] got,
                              input logic [`MUL_XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Only tag and destination come back out of the top
    task automatic check_info(input inst_info_t got, input inst_info_t exp);
        if (got.rob_tag !== exp.rob_tag) begin
            errors++;
            $display("Error at %0t ns: wb_rob_tag = %h, expected %h",
                     $time, got.rob_tag, exp.rob_tag);
        end
        if (got.pd !== exp.pd) begin
            errors++;
            $display("Error at %0t ns: wb_pd = %h, expected %h", $time, got.pd, exp.pd);
        end
    endtask

    task automatic check_op(input string name, input mul_op_t got, input mul_op_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic complain(input string what);
        errors++;
        $display("At %0t ns: %s", $time, what);
    endtask

    // Called on a falling edge, returns on the next falling edge
    task automatic bus_write(input logic [`MUL_PREG_W-1:0] pd, input logic [`MUL_XLEN-1:0] data);
        bus_we   = 1'b1;
        bus_pd   = pd;
        bus_data = data;
        @(negedge clk);
        bus_we = 1'b0;
        if (pd != '0)
            shadow[pd] = data;
    endtask

    // Issue one multiply and follow it to writeback
    // With clash set, a bus write to the same pd lands in the writeback cycle
    task automatic run_mul(input mul_op_t op, input logic [`MUL_PREG_W-1:0] ps1,
                           input logic [`MUL_PREG_W-1:0] ps2,
                           input logic [`MUL_PREG_W-1:0] pd, input bit clash);
        logic [`MUL_XLEN-1:0] exp_val;
        logic [31:0]          clash_data;
        inst_info_t           exp_info;
        inst_info_t           got_info;
        int                   cycles;
        if (!fu_ready)
            complain("unit not ready when an issue was due");
        exp_val          = expected_product(op, shadow[ps1], shadow[ps2]);
        exp_info         = '0;
        exp_info.rob_tag = next_tag;
        exp_info.pd      = pd;
        got_info         = '0;
        issue_start      = 1'b1;
        issue_rob_tag    = next_tag;
        issue_pd         = pd;
        issue_ps1        = ps1;
        issue_ps2        = ps2;
        issue_mul_type   = op;
        in_flight        = 1'b1;
        issued++;
        next_tag++;
        // Ready drops combinationally with the strobe
        #1;
        if (fu_ready)
            complain("fu_ready still high in the issue cycle");
        @(negedge clk);
        issue_start = 1'b0;
        cycles      = 1;
        while (!wb_valid && cycles < 60) begin
            if (fu_ready)
                complain("fu_ready rose before the result");
            @(negedge clk);
            cycles++;
        end
        if (!wb_valid) begin
            complain("no writeback within 60 cycles of the issue");
            in_flight = 1'b0;
            return;
        end
        check_word("wb_value", wb_value, exp_val);
        got_info.rob_tag = wb_rob_tag;
        got_info.pd      = wb_pd;
        check_info(got_info, exp_info);
        check_op("core mul_type", uut.core_bus.mul_type, op);
        if (fu_ready)
            complain("fu_ready high in the writeback cycle");
        if (clash) begin
            take_bits(32, clash_data);
            bus_we   = 1'b1;
            bus_pd   = pd;
            bus_data = clash_data;
        end
        // Multiplier write wins over the bus
        if (pd != '0)
            shadow[pd] = exp_val;
        @(negedge clk);
        bus_we    = 1'b0;
        in_flight = 1'b0;
        if (wb_valid)
            complain("wb_valid held for a second cycle");
        if (!fu_ready)
            complain("fu_ready still low after the writeback cycle");
    endtask

    task automatic run_random(input bit clash);
        logic [31:0] r;
        take_bits(2 + 3 * `MUL_PREG_W, r);
        run_mul(mul_op_t'(r[1:0]), r[7:2], r[13:8], r[19:14], clash);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("Test %s: pass", name);
        end else begin
            failed++;
            $display("Test %s: FAIL with %0d errors", name, errors - errs_before);
        end
    endtask

    // Sampled before the edge updates, so a result is seen once
    always @(posedge clk) begin
        if (!rst && wb_valid) begin
            wb_seen++;
            if (!in_flight)
                complain("writeback with no multiply in flight");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int          mark;
        logic [31:0] r;
        logic [31:0] corners [5];
        clk            = 1'b0;
        rst            = 1'b1;
        issue_start    = 1'b0;
        issue_rob_tag  = '0;
        issue_pd       = '0;
        issue_ps1      = '0;
        issue_ps2      = '0;
        issue_mul_type = op_mul;
        bus_we         = 1'b0;
        bus_pd         = '0;
        bus_data       = '0;
        lfsr_state     = 32'h618ab935;
        next_tag       = '0;
        in_flight      = 1'b0;
        errors         = 0;
        passed         = 0;
        failed         = 0;
        issued         = 0;
        wb_seen        = 0;
        corners        = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        for (int i = 0; i < `MUL_PREGS; i++)
            shadow[i] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle state after reset
        mark = errors;
        if (!fu_ready)
            complain("fu_ready low after reset");
        if (wb_valid)
            complain("wb_valid high after reset");
        // Fill every register from the bus, register 0 included
        for (int i = 0; i < `MUL_PREGS; i++) begin
            take_bits(32, r);
            bus_write(i[`MUL_PREG_W-1:0], r);
        end
        // Register 0 on either side zeroes the product
        for (int i = 0; i < N_ZERO; i++) begin
            take_bits(12, r);
            if (i < N_ZERO / 2)
                run_mul(mul_op_t'(i % 4), '0, r[5:0], r[11:6], 1'b0);
            else
                run_mul(mul_op_t'(i % 4), r[5:0], '0, r[11:6], 1'b0);
        end
        report_test("reset and zero register", mark);

        // Random issues on the loaded registers
        mark = errors;
        for (int i = 0; i < N_RAND; i++)
            run_random(1'b0);
        report_test("random multiplies", mark);

        // Corners in registers 1 to 5, results kept in the upper half
        mark = errors;
        for (int i = 0; i < 5; i++)
            bus_write(6'(i + 1), corners[i]);
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int k = 0; k < 4; k++) begin
                    take_bits(5, r);
                    run_mul(mul_op_t'(k), 6'(i + 1), 6'(j + 1), {1'b1, r[4:0]}, 1'b0);
                end
            end
        end
        report_test("corner operands", mark);

        mark = errors;
        for (int i = 0; i < N_READY; i++)
            run_random(1'b0);
        report_test("ready handshake", mark);

        // Result feeds the next issue, after losing nothing to a bus clash
        mark = errors;
        for (int i = 0; i < N_CHAIN / 2; i++) begin
            take_bits(20, r);
            run_mul(mul_op_t'(r[1:0]), r[7:2], r[13:8], {1'b1, r[18:14]}, 1'b1);
            take_bits(14, r);
            run_mul(mul_op_t'(r[1:0]), issue_pd, r[7:2], r[13:8], 1'b0);
        end
        report_test("writeback forwarding", mark);

        mark = errors;
        for (int i = 0; i < N_BURST; i++)
            run_random(1'b0);
        report_test("back to back issues", mark);

        repeat (4) @(negedge clk);
        if (wb_seen != issued)
            complain($sformatf("%0d writebacks for %0d issues", wb_seen, issued));
        $display("Tests passed: %0d, failed: %0d, errors: %0d", passed, failed, errors);
        if (failed == 0 && errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : tb_mul_unit

`default_nettype wire

//--- design/mul_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_unit_top (
    input  logic                    clk,
    input  logic                    rst,
    // Issue from the reservation station
    input  logic                    issue_start,
    input  logic [`MUL_TAG_W-1:0]   issue_rob_tag,
    input  logic [`MUL_PREG_W-1:0]  issue_pd,
    input  logic [`MUL_PREG_W-1:0]  issue_ps1,
    input  logic [`MUL_PREG_W-1:0]  issue_ps2,
    input  mul_types_pkg::mul_op_t  issue_mul_type,
    output logic                    fu_ready,
    // Other units' bus write
    input  logic                    bus_we,
    input  logic [`MUL_PREG_W-1:0]  bus_pd,
    input  logic [`MUL_XLEN-1:0]    bus_data,
    // Multiplier writeback
    output logic                    wb_valid,
    output logic [`MUL_TAG_W-1:0]   wb_rob_tag,
    output logic [`MUL_PREG_W-1:0]  wb_pd,
    output logic [`MUL_XLEN-1:0]    wb_value
);
    import mul_types_pkg::*;

    fu_input_t               issue;
    fu_output_t              wb;
    physical_reg_response_t  rs_data;

    mul_core_if core_bus ();

    // Pack the issue fields
    assign issue.start_calculate    = issue_start;
    assign issue.inst_info.rob_tag  = issue_rob_tag;
    assign issue.inst_info.pd       = issue_pd;
    assign issue.inst_info.ps1      = issue_ps1;
    assign issue.inst_info.ps2      = issue_ps2;
    assign issue.inst_info.mul_type = issue_mul_type;

    phys_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .ps1      (issue_ps1),
        .ps2      (issue_ps2),
        .rs_data  (rs_data),
        .bus_we   (bus_we),
        .bus_pd   (bus_pd),
        .bus_data (bus_data),
        .wb       (wb)
    );

    fu_wrapper_mult u_wrapper (
        .clk              (clk),
        .rst              (rst),
        .to_be_multiplied (issue),
        .fu_reg_data      (rs_data),
        .fu_ready         (fu_ready),
        .mul_output       (wb),
        .core             (core_bus)
    );

    shift_add_multiplier u_mult (
        .clk  (clk),
        .rst  (rst),
        .core (core_bus)
    );

    // Unpack the writeback record
    assign wb_valid   = wb.ready_for_writeback;
    assign wb_rob_tag = wb.inst_info.rob_tag;
    assign wb_pd      = wb.inst_info.pd;
    assign wb_value   = wb.register_value;

endmodule : mul_unit_top

`default_nettype wire

//--- design/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module phys_regfile (
    input  logic                                   clk,
    input  logic                                   rst,
    // Source indices for the two read ports
    input  logic [`MUL_PREG_W-1:0]                 ps1,
    input  logic [`MUL_PREG_W-1:0]                 ps2,
    output mul_types_pkg::physical_reg_response_t  rs_data,
    // Write port standing in for the other units on the bus
    input  logic                                   bus_we,
    input  logic [`MUL_PREG_W-1:0]                 bus_pd,
    input  logic [`MUL_XLEN-1:0]                   bus_data,
    // Multiplier writeback record
    input  mul_types_pkg::fu_output_t              wb
);

    logic [`MUL_XLEN-1:0] regs [`MUL_PREGS];

    // Register 0 is never written so it reads as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MUL_PREGS; i++)
                regs[i] <= '0;
        end else begin
            if (bus_we && bus_pd != '0)
                regs[bus_pd] <= bus_data;
            // Later assignment, so the multiplier wins a same-register clash
            if (wb.ready_for_writeback && wb.inst_info.pd != '0)
                regs[wb.inst_info.pd] <= wb.register_value;
        end
    end

    // Combinational read, sees every write up to the last edge
    assign rs_data.rs1_v = regs[ps1];
    assign rs_data.rs2_v = regs[ps2];

endmodule : phys_regfile

`default_nettype wire

//--- design/fu_wrapper_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module fu_wrapper_mult (
    input  logic                                   clk,
    input  logic                                   rst,
    // Issue from the reservation station
    input  mul_types_pkg::fu_input_t               to_be_multiplied,
    // Operand values read in the issue cycle
    input  mul_types_pkg::physical_reg_response_t  fu_reg_data,
    // Unit can take a new multiply
    output logic                                   fu_ready,
    // Result record toward the common data bus
    output mul_types_pkg::fu_output_t              mul_output,
    mul_core_if.wrapper                            core
);
    import mul_types_pkg::*;

    logic                  issue;
    logic                  avail;
    logic                  start_q;
    logic [`MUL_XLEN-1:0]  a_q;
    logic [`MUL_XLEN-1:0]  b_q;
    inst_info_t            info_q;

    assign issue = to_be_multiplied.start_calculate;

    // Operand and tag capture, payload only
    always_ff @(posedge clk) begin
        if (issue) begin
            a_q    <= fu_reg_data.rs1_v;
            b_q    <= fu_reg_data.rs2_v;
            info_q <= to_be_multiplied.inst_info;
        end
    end

    // Start rises the edge after issue and falls the edge after done
    always_ff @(posedge clk) begin
        if (rst)
            start_q <= 1'b0;
        else if (issue)
            start_q <= 1'b1;
        else if (core.done)
            start_q <= 1'b0;
    end

    // Busy from issue until the result cycle
    always_ff @(posedge clk) begin
        if (rst)
            avail <= 1'b1;
        else if (issue)
            avail <= 1'b0;
        else if (core.done)
            avail <= 1'b1;
    end

    // Drop ready in the issue cycle itself
    assign fu_ready = avail & ~issue;

    assign core.start    = start_q;
    assign core.mul_type = info_q.mul_type;
    assign core.a        = a_q;
    assign core.b        = b_q;

    // MUL returns the low word, the MULH family the high word
    always_comb begin
        if (core.done) begin
            mul_output.ready_for_writeback = 1'b1;
            mul_output.inst_info           = info_q;
            if (info_q.mul_type == op_mul)
                mul_output.register_value = core.p[`MUL_XLEN-1:0];
            else
                mul_output.register_value = core.p[2*`MUL_XLEN-1:`MUL_XLEN];
        end else begin
            mul_output = '0;
        end
    end

    // Reservation station only issues on ready
    a_issue_when_avail: assert property (@(posedge clk) disable iff (rst)
        issue |-> avail);

endmodule : fu_wrapper_mult

`default_nettype wire

//--- design/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module shift_add_multiplier (
    input  logic        clk,
    input  logic        rst,
    mul_core_if.core    core
);
    import mul_types_pkg::*;

    localparam int XLEN  = `MUL_XLEN;
    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } state_t;

    state_t              state;
    logic [CNT_W-1:0]    count;
    logic [2*XLEN-1:0]   acc;
    logic [2*XLEN-1:0]   mcand;
    logic [XLEN-1:0]     mplier;
    logic                negate;
    logic                a_signed;
    logic                b_signed;
    logic                a_neg;
    logic                b_neg;
    logic [XLEN-1:0]     a_mag;
    logic [XLEN-1:0]     b_mag;

    // MULH treats both operands as signed, MULHSU only rs1
    // Low word of MUL is the same either way, so it runs unsigned
    always_comb begin
        a_signed = (core.mul_type == op_mulh) || (core.mul_type == op_mulhsu);
        b_signed = (core.mul_type == op_mulh);
        a_neg    = a_signed & core.a[XLEN-1];
        b_neg    = b_signed & core.b[XLEN-1];
        // Most negative value maps to 2**31, still fits unsigned
        a_mag    = a_neg ? -core.a : core.a;
        b_mag    = b_neg ? -core.b : core.b;
    end

    // Control FSM
    // One load cycle, XLEN iterations, one done cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (core.start) begin
                        state <= st_busy;
                        count <= '0;
                    end
                end
                st_busy: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(XLEN - 1))
                        state <= st_done;
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Datapath, one partial product per busy cycle
    always_ff @(posedge clk) begin
        if (state == st_idle && core.start) begin
            acc    <= '0;
            mcand  <= {{XLEN{1'b0}}, a_mag};
            mplier <= b_mag;
            negate <= a_neg ^ b_neg;
        end else if (state == st_busy) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign core.done = (state == st_done);
    // Sign restored on the magnitude product
    assign core.p    = negate ? -acc : acc;

    // Wrapper must still be holding start when we finish
    a_done_needs_start: assert property (@(posedge clk) disable iff (rst)
        core.done |-> core.start);

    // Operands latched by the wrapper must not move mid-computation
    a_operands_stable: assert property (@(posedge clk) disable iff (rst)
        (state != st_idle) |-> ($stable(core.a) && $stable(core.b) &&
                                $stable(core.mul_type)));

endmodule : shift_add_multiplier

`default_nettype wire

//--- design/mul_core_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

interface mul_core_if;
    import mul_types_pkg::*;

    // Held high with operands stable until done
    logic                   start;
    mul_op_t                mul_type;
    logic [`MUL_XLEN-1:0]   a;
    logic [`MUL_XLEN-1:0]   b;
    // Full 64-bit product, valid only while done is high
    logic [2*`MUL_XLEN-1:0] p;
    // One-cycle completion pulse
    logic                   done;

    // Functional-unit side
    modport wrapper (
        output start, mul_type, a, b,
        input  p, done
    );

    // Multiplier side
    modport core (
        input  start, mul_type, a, b,
        output p, done
    );

endinterface : mul_core_if

`default_nettype wire

//--- design/mul_types_pkg.sv
`default_nettype none

`include "mul_consts.svh"

package mul_types_pkg;

    // M-extension multiply variants handled by this unit
    // Encoding follows funct3[1:0] of MUL/MULH/MULHSU/MULHU
    typedef enum logic [1:0] {
        op_mul    = 2'b00,
        op_mulh   = 2'b01,
        op_mulhsu = 2'b10,
        op_mulhu  = 2'b11
    } mul_op_t;

    // Bookkeeping that follows an instruction through the unit
    typedef struct packed {
        logic [`MUL_TAG_W-1:0]  rob_tag;
        // Destination physical register
        logic [`MUL_PREG_W-1:0] pd;
        // Source physical registers
        logic [`MUL_PREG_W-1:0] ps1;
        logic [`MUL_PREG_W-1:0] ps2;
        mul_op_t                mul_type;
    } inst_info_t;

    // Issue from the reservation station
    // start_calculate is a single-cycle strobe
    typedef struct packed {
        logic       start_calculate;
        inst_info_t inst_info;
    } fu_input_t;

    // Source operand values from the register file
    typedef struct packed {
        logic [`MUL_XLEN-1:0] rs1_v;
        logic [`MUL_XLEN-1:0] rs2_v;
    } physical_reg_response_t;

    // Writeback record, valid for one cycle, never stalled
    typedef struct packed {
        logic                 ready_for_writeback;
        inst_info_t           inst_info;
        logic [`MUL_XLEN-1:0] register_value;
    } fu_output_t;

endpackage : mul_types_pkg

`default_nettype wire

//--- include/mul_consts.svh
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// Integer register width of the RV32 datapath
`define MUL_XLEN 32

// Physical register file depth
`define MUL_PREGS 64

// Index width into the physical register file
`define MUL_PREG_W 6

// Reorder-buffer tag width
`define MUL_TAG_W 5

`endif
